//--- src/conv_pkg.sv
package conv_pkg;

    // Sample format, signed with 16 fraction bits
    localparam int PIXEL_W   = 20;
    localparam int ACC_W     = 2 * PIXEL_W;
    localparam int FRAC_BITS = 16;

    typedef logic signed [PIXEL_W-1:0] pixel_t;
    typedef logic signed [ACC_W-1:0]   acc_t;

    // 3x3 kernel, row-major
    localparam pixel_t KERNEL_WEIGHTS [0:8] = '{
        20'h0ab9e, 20'h092d5, 20'h06d43,
        20'h01004, 20'hf8f71, 20'hf6e54,
        20'hfa6d7, 20'hfc834, 20'hfac19
    };

    localparam pixel_t CONV_BIAS = 20'h01310;

    // Half an LSB of the output pixel, for round half up
    localparam acc_t ROUND_HALF = acc_t'(1) <<< (FRAC_BITS - 1);

    // Chip selects of the result memories
    localparam logic [2:0] CSEL_NONE   = 3'b000;
    localparam logic [2:0] CSEL_LAYER0 = 3'b001;
    localparam logic [2:0] CSEL_LAYER1 = 3'b011;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_LOAD,
        ST_MAC,
        ST_RELU,
        ST_WRITE0,
        ST_STEP0,
        ST_READ,
        ST_POOL,
        ST_WRITE1,
        ST_STEP1,
        ST_DONE
    } ctrl_state_t;

endpackage

//--- src/layer_ctrl.sv
`timescale 1ns/1ps

module layer_ctrl
    import conv_pkg::*;
#(
    parameter int  IMAGE_WIDTH = 64,
    localparam int PTR_W       = $clog2(IMAGE_WIDTH),
    localparam int ADDR_W      = $clog2(IMAGE_WIDTH * IMAGE_WIDTH)
)
(
    input  logic              clk,
    input  logic              reset,
    input  logic              ready,
    input  logic              window_done,
    input  pixel_t            relu_result,
    input  pixel_t            pool_result,
    output logic              busy,
    output logic [ADDR_W-1:0] iaddr,
    output logic              crd,
    output logic [ADDR_W-1:0] caddr_rd,
    output logic              cwr,
    output logic [2:0]        csel,
    output logic [ADDR_W-1:0] caddr_wr,
    output pixel_t            cdata_wr,
    output logic [PTR_W-1:0]  row_ptr,
    output logic [PTR_W-1:0]  col_ptr,
    output logic              load_image,
    output logic              load_layer0,
    output logic              mac_run,
    output logic              relu_take,
    output logic              pool_take
);

    ctrl_state_t       state;
    ctrl_state_t       state_next;
    logic              col_end;
    logic              frame_last;
    logic              pool_col_end;
    logic              pool_last;
    logic              out_sel;
    logic [ADDR_W-1:0] frame_addr;
    logic [ADDR_W-1:0] pool_addr;

    // Raster end flags, stride 1 and stride 2
    assign col_end      = (col_ptr == PTR_W'(IMAGE_WIDTH - 1));
    assign frame_last   = col_end && (row_ptr == PTR_W'(IMAGE_WIDTH - 1));
    assign pool_col_end = (col_ptr == PTR_W'(IMAGE_WIDTH - 2));
    assign pool_last    = pool_col_end && (row_ptr == PTR_W'(IMAGE_WIDTH - 2));

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:   state_next = ready ? ST_LOAD : ST_IDLE;
            ST_LOAD:   state_next = frame_last ? ST_MAC : ST_LOAD;
            ST_MAC:    state_next = window_done ? ST_RELU : ST_MAC;
            ST_RELU:   state_next = ST_WRITE0;
            ST_WRITE0: state_next = ST_STEP0;
            ST_STEP0:  state_next = frame_last ? ST_READ : ST_MAC;
            ST_READ:   state_next = frame_last ? ST_POOL : ST_READ;
            ST_POOL:   state_next = ST_WRITE1;
            ST_WRITE1: state_next = ST_STEP1;
            ST_STEP1:  state_next = pool_last ? ST_DONE : ST_POOL;
            ST_DONE:   state_next = ST_DONE;
            default:   state_next = ST_IDLE;
        endcase
    end

    // Frame pointers, wrap to origin at the end of each pass
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            row_ptr <= '0;
            col_ptr <= '0;
        end
        else
        begin
            case (state)
                ST_LOAD, ST_STEP0, ST_READ:
                begin
                    if (frame_last)
                    begin
                        row_ptr <= '0;
                        col_ptr <= '0;
                    end
                    else if (col_end)
                    begin
                        row_ptr <= row_ptr + PTR_W'(1);
                        col_ptr <= '0;
                    end
                    else
                    begin
                        col_ptr <= col_ptr + PTR_W'(1);
                    end
                end
                ST_STEP1:
                begin
                    if (pool_last)
                    begin
                        row_ptr <= '0;
                        col_ptr <= '0;
                    end
                    else if (pool_col_end)
                    begin
                        row_ptr <= row_ptr + PTR_W'(2);
                        col_ptr <= '0;
                    end
                    else
                    begin
                        col_ptr <= col_ptr + PTR_W'(2);
                    end
                end
                default:
                begin
                end
            endcase
        end
    end

    assign frame_addr = ADDR_W'(row_ptr) * ADDR_W'(IMAGE_WIDTH) + ADDR_W'(col_ptr);
    assign pool_addr  = ADDR_W'(row_ptr >> 1) * ADDR_W'(IMAGE_WIDTH / 2)
                        + ADDR_W'(col_ptr >> 1);

    // Phase strobes
    assign load_image  = (state == ST_LOAD);
    assign load_layer0 = (state == ST_READ);
    assign mac_run     = (state == ST_MAC);
    assign relu_take   = (state == ST_RELU);
    assign pool_take   = (state == ST_POOL);
    assign out_sel     = (state == ST_WRITE1);

    assign busy = (state != ST_IDLE) && (state != ST_DONE);
    assign crd  = load_layer0;
    assign cwr  = (state == ST_WRITE0) || out_sel;

    // Layer-0 memory stays selected while it is read back
    assign csel = (state == ST_WRITE0 || load_layer0) ? CSEL_LAYER0 :
                  out_sel                             ? CSEL_LAYER1 : CSEL_NONE;

    assign iaddr    = load_image ? frame_addr : '0;
    assign caddr_rd = crd ? frame_addr : '0;
    assign caddr_wr = out_sel ? pool_addr : (cwr ? frame_addr : '0);
    assign cdata_wr = !cwr ? '0 : (out_sel ? pool_result : relu_result);

endmodule

//--- src/image_buffer.sv
`timescale 1ns/1ps

module image_buffer
    import conv_pkg::*;
#(
    parameter int  IMAGE_WIDTH = 64,
    localparam int PTR_W       = $clog2(IMAGE_WIDTH),
    localparam int ADDR_W      = $clog2(IMAGE_WIDTH * IMAGE_WIDTH)
)
(
    input  logic             clk,
    input  logic             reset,
    input  logic             load_image,
    input  logic             load_layer0,
    input  pixel_t           idata,
    input  pixel_t           cdata_rd,
    input  logic [PTR_W-1:0] row_ptr,
    input  logic [PTR_W-1:0] col_ptr,
    input  logic [1:0]       win_row,
    input  logic [1:0]       win_col,
    output pixel_t           window_pixel,
    output pixel_t           pool_a,
    output pixel_t           pool_b,
    output pixel_t           pool_c,
    output pixel_t           pool_d
);

    pixel_t                   mem [0:IMAGE_WIDTH*IMAGE_WIDTH-1];
    logic                     image_d;
    logic                     layer0_d;
    logic [ADDR_W-1:0]        frame_addr;
    logic [ADDR_W-1:0]        wr_addr_d;
    logic signed [PTR_W+1:0]  pad_row;
    logic signed [PTR_W+1:0]  pad_col;
    logic                     in_frame;
    logic [ADDR_W-1:0]        win_addr;

    assign frame_addr = ADDR_W'(row_ptr) * ADDR_W'(IMAGE_WIDTH) + ADDR_W'(col_ptr);

    // Read data lags the address by one clock
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            image_d  <= 1'b0;
            layer0_d <= 1'b0;
        end
        else
        begin
            image_d  <= load_image;
            layer0_d <= load_layer0;
        end
    end

    always_ff @(posedge clk)
    begin
        wr_addr_d <= frame_addr;
        if (image_d)
        begin
            mem[wr_addr_d] <= idata;
        end
        else if (layer0_d)
        begin
            mem[wr_addr_d] <= cdata_rd;
        end
    end

    // Window position relative to the frame, offset 1 is the centre
    assign pad_row = $signed({2'b00, row_ptr}) + $signed({{PTR_W{1'b0}}, win_row})
                     - (PTR_W+2)'(1);
    assign pad_col = $signed({2'b00, col_ptr}) + $signed({{PTR_W{1'b0}}, win_col})
                     - (PTR_W+2)'(1);
    assign in_frame = (pad_row >= 0) && (pad_row < IMAGE_WIDTH)
                      && (pad_col >= 0) && (pad_col < IMAGE_WIDTH);
    assign win_addr = ADDR_W'(pad_row[PTR_W-1:0]) * ADDR_W'(IMAGE_WIDTH)
                      + ADDR_W'(pad_col[PTR_W-1:0]);

    assign window_pixel = in_frame ? mem[win_addr] : '0;

    // 2x2 block with its top-left corner at the pointers
    assign pool_a = mem[frame_addr];
    assign pool_b = mem[frame_addr + ADDR_W'(1)];
    assign pool_c = mem[frame_addr + ADDR_W'(IMAGE_WIDTH)];
    assign pool_d = mem[frame_addr + ADDR_W'(IMAGE_WIDTH + 1)];

endmodule

//--- src/conv_mac.sv
`timescale 1ns/1ps

module conv_mac
    import conv_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       mac_run,
    input  logic       relu_take,
    input  pixel_t     window_pixel,
    output logic [1:0] win_row,
    output logic [1:0] win_col,
    output logic       window_done,
    output pixel_t     relu_result
);

    logic [3:0] kernel_idx;
    pixel_t     weight;
    acc_t       product;
    acc_t       acc;
    acc_t       biased;
    acc_t       rounded;
    pixel_t     scaled;

    assign window_done = mac_run && (win_row == 2'd2) && (win_col == 2'd2);

    // 3x3 offset walk, row-major
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            win_row <= 2'd0;
            win_col <= 2'd0;
        end
        else if (mac_run)
        begin
            if (win_col == 2'd2)
            begin
                win_col <= 2'd0;
                win_row <= (win_row == 2'd2) ? 2'd0 : win_row + 2'd1;
            end
            else
            begin
                win_col <= win_col + 2'd1;
            end
        end
    end

    assign kernel_idx = {2'b00, win_row} * 4'd3 + {2'b00, win_col};
    assign weight     = KERNEL_WEIGHTS[kernel_idx];
    assign product    = window_pixel * weight;

    // Sum of the window, emptied once the result has been taken
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            acc <= '0;
        end
        else if (relu_take)
        begin
            acc <= '0;
        end
        else if (mac_run)
        begin
            acc <= acc + product;
        end
    end

    // Bias aligned to the product scale, then round half up
    assign biased  = acc + (acc_t'(CONV_BIAS) <<< FRAC_BITS);
    assign rounded = biased + ROUND_HALF;
    assign scaled  = rounded[FRAC_BITS+PIXEL_W-1:FRAC_BITS];

    always_ff @(posedge clk)
    begin
        if (relu_take)
        begin
            relu_result <= scaled[PIXEL_W-1] ? '0 : scaled;
        end
    end

endmodule

//--- src/max_pool.sv
`timescale 1ns/1ps

module max_pool
    import conv_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   pool_take,
    input  pixel_t pool_a,
    input  pixel_t pool_b,
    input  pixel_t pool_c,
    input  pixel_t pool_d,
    output pixel_t pool_result
);

    pixel_t max_top;
    pixel_t max_bottom;
    pixel_t max_all;

    // Upper pair, lower pair, then the winner of both
    assign max_top    = (pool_a > pool_b) ? pool_a : pool_b;
    assign max_bottom = (pool_c > pool_d) ? pool_c : pool_d;
    assign max_all    = (max_top > max_bottom) ? max_top : max_bottom;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pool_result <= '0;
        end
        else if (pool_take)
        begin
            pool_result <= max_all;
        end
    end

endmodule

//--- src/conv_accel.sv
`timescale 1ns/1ps

module conv_accel
    import conv_pkg::*;
#(
    parameter int  IMAGE_WIDTH = 64,
    localparam int PTR_W       = $clog2(IMAGE_WIDTH),
    localparam int ADDR_W      = $clog2(IMAGE_WIDTH * IMAGE_WIDTH)
)
(
    input  logic              clk,
    input  logic              reset,
    input  logic              ready,
    input  pixel_t            idata,
    input  pixel_t            cdata_rd,
    output logic              busy,
    output logic [ADDR_W-1:0] iaddr,
    output logic              crd,
    output logic [ADDR_W-1:0] caddr_rd,
    output logic              cwr,
    output logic [2:0]        csel,
    output logic [ADDR_W-1:0] caddr_wr,
    output pixel_t            cdata_wr
);

    logic [PTR_W-1:0] row_ptr;
    logic [PTR_W-1:0] col_ptr;
    logic             load_image;
    logic             load_layer0;
    logic             mac_run;
    logic             relu_take;
    logic             pool_take;
    logic             window_done;
    logic [1:0]       win_row;
    logic [1:0]       win_col;
    pixel_t           window_pixel;
    pixel_t           pool_a;
    pixel_t           pool_b;
    pixel_t           pool_c;
    pixel_t           pool_d;
    pixel_t           relu_result;
    pixel_t           pool_result;

    layer_ctrl #(
        .IMAGE_WIDTH (IMAGE_WIDTH)
    ) i_layer_ctrl (
        .clk         (clk),
        .reset       (reset),
        .ready       (ready),
        .window_done (window_done),
        .relu_result (relu_result),
        .pool_result (pool_result),
        .busy        (busy),
        .iaddr       (iaddr),
        .crd         (crd),
        .caddr_rd    (caddr_rd),
        .cwr         (cwr),
        .csel        (csel),
        .caddr_wr    (caddr_wr),
        .cdata_wr    (cdata_wr),
        .row_ptr     (row_ptr),
        .col_ptr     (col_ptr),
        .load_image  (load_image),
        .load_layer0 (load_layer0),
        .mac_run     (mac_run),
        .relu_take   (relu_take),
        .pool_take   (pool_take)
    );

    image_buffer #(
        .IMAGE_WIDTH (IMAGE_WIDTH)
    ) i_image_buffer (
        .clk          (clk),
        .reset        (reset),
        .load_image   (load_image),
        .load_layer0  (load_layer0),
        .idata        (idata),
        .cdata_rd     (cdata_rd),
        .row_ptr      (row_ptr),
        .col_ptr      (col_ptr),
        .win_row      (win_row),
        .win_col      (win_col),
        .window_pixel (window_pixel),
        .pool_a       (pool_a),
        .pool_b       (pool_b),
        .pool_c       (pool_c),
        .pool_d       (pool_d)
    );

    conv_mac i_conv_mac (
        .clk          (clk),
        .reset        (reset),
        .mac_run      (mac_run),
        .relu_take    (relu_take),
        .window_pixel (window_pixel),
        .win_row      (win_row),
        .win_col      (win_col),
        .window_done  (window_done),
        .relu_result  (relu_result)
    );

    max_pool i_max_pool (
        .clk         (clk),
        .reset       (reset),
        .pool_take   (pool_take),
        .pool_a      (pool_a),
        .pool_b      (pool_b),
        .pool_c      (pool_c),
        .pool_d      (pool_d),
        .pool_result (pool_result)
    );

endmodule

//--- testbench/conv_accel_props.sv
`timescale 1ns/1ps

module conv_accel_props
    import conv_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       ready,
    input logic       busy,
    input logic       crd,
    input logic       cwr,
    input logic [2:0] csel
);

    // Every write goes to one of the two result memories
    write_csel_valid: assert property (@(posedge clk) disable iff (reset)
        cwr |-> (csel == CSEL_LAYER0 || csel == CSEL_LAYER1))
        else $error("cwr high with csel %b", csel);

    read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(crd && cwr))
        else $error("crd and cwr high in the same cycle");

    // A run starts only from ready
    busy_needs_ready: assert property (@(posedge clk) disable iff (reset)
        (!busy && !ready) |=> !busy)
        else $error("busy rose without ready");

endmodule

bind conv_accel conv_accel_props i_conv_accel_props (
    .clk   (clk),
    .reset (reset),
    .ready (ready),
    .busy  (busy),
    .crd   (crd),
    .cwr   (cwr),
    .csel  (csel)
);

//--- testbench/tb_conv_accel.sv
`timescale 1ns/1ps

module tb_conv_accel
    import conv_pkg::*;
;

    localparam int IMAGE_WIDTH     = 4;
    localparam int NPIX            = IMAGE_WIDTH * IMAGE_WIDTH;
    localparam int NPOOL           = NPIX / 4;
    localparam int ADDR_W          = $clog2(NPIX);
    localparam int WATCHDOG_CYCLES = 2 * (NPIX * 14) + 200;

    logic              clk;
    logic              reset;
    logic              ready;
    pixel_t            idata;
    pixel_t            cdata_rd;
    logic              busy;
    logic [ADDR_W-1:0] iaddr;
    logic              crd;
    logic [ADDR_W-1:0] caddr_rd;
    logic              cwr;
    logic [2:0]        csel;
    logic [ADDR_W-1:0] caddr_wr;
    pixel_t            cdata_wr;

    pixel_t stim [0:2*NPIX+NPOOL-1];
    pixel_t rom [0:NPIX-1];
    pixel_t l0_mem [0:NPIX-1];
    pixel_t l1_mem [0:NPOOL-1];
    int     rom_hits [0:NPIX-1];

    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    int busy_cycles;
    int l0_writes;
    int l0_reads;
    int l1_writes;
    int writes_at_fall;
    bit busy_seen;
    bit fall_seen;
    int rom_errs;
    int l0_errs;
    int l1_errs;

    conv_accel #(
        .IMAGE_WIDTH (IMAGE_WIDTH)
    ) i_conv_accel (
        .clk      (clk),
        .reset    (reset),
        .ready    (ready),
        .idata    (idata),
        .cdata_rd (cdata_rd),
        .busy     (busy),
        .iaddr    (iaddr),
        .crd      (crd),
        .caddr_rd (caddr_rd),
        .cwr      (cwr),
        .csel     (csel),
        .caddr_wr (caddr_wr),
        .cdata_wr (cdata_wr)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_csel(input string name, input logic [2:0] got, input logic [2:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic fail_plain(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic report_test(input int num, input string title, input int errs);
        tests_run++;
        if (errs == 0)
        begin
            $display("Test %0d %s: ok", num, title);
        end
        else
        begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", num, title, errs);
        end
    endtask

    // ROM and result memory models with one-cycle read latency and a bus monitor
    always @(posedge clk)
    begin
        int e0;
        logic [2:0] exp_csel;
        idata    <= rom[iaddr];
        cdata_rd <= l0_mem[caddr_rd];
        if (!reset)
        begin
            e0 = errors;
            if (busy)
            begin
                busy_seen = 1'b1;
                if (fall_seen)
                begin
                    fail_plain("busy rose again after the run ended");
                end
                if (busy_cycles < NPIX)
                begin
                    rom_hits[iaddr]++;
                    check_addr("iaddr", iaddr, ADDR_W'(busy_cycles));
                end
                busy_cycles++;
            end
            else if (busy_seen && !fall_seen)
            begin
                fall_seen      = 1'b1;
                writes_at_fall = l1_writes;
            end
            rom_errs += errors - e0;
            e0 = errors;
            // Layer-0 read-back walks the frame in raster order
            if (crd)
            begin
                if (l0_writes != NPIX)
                begin
                    fail_plain("layer-0 read-back started before the last layer-0 write");
                end
                check_addr("caddr_rd", caddr_rd, ADDR_W'(l0_reads));
                l0_reads++;
                l1_errs += errors - e0;
            end
            e0 = errors;
            if (cwr)
            begin
                check_flag("busy during write", busy, 1'b1);
                exp_csel = (l0_writes < NPIX) ? CSEL_LAYER0 : CSEL_LAYER1;
                check_csel("csel", csel, exp_csel);
                if (exp_csel == CSEL_LAYER0)
                begin
                    check_addr("caddr_wr layer0", caddr_wr, ADDR_W'(l0_writes));
                    l0_mem[caddr_wr] = cdata_wr;
                    l0_writes++;
                    l0_errs += errors - e0;
                end
                else
                begin
                    check_addr("caddr_wr layer1", caddr_wr, ADDR_W'(l1_writes));
                    if (caddr_wr < NPOOL)
                    begin
                        l1_mem[caddr_wr] = cdata_wr;
                    end
                    l1_writes++;
                    l1_errs += errors - e0;
                end
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

    initial
    begin
        int idle;
        int e0;
        int neg_count;
        void'($urandom(32'h754f));
        reset    = 1'b1;
        ready    = 1'b0;
        idata    = '0;
        cdata_rd = '0;
        $readmemh("testbench/conv_stimulus.txt", stim);
        for (int i = 0; i < NPIX; i++)
        begin
            rom[i]      = stim[i];
            rom_hits[i] = 0;
            l0_mem[i]   = pixel_t'(20'hc0000 | (i * 20'h00111));
        end
        for (int i = 0; i < NPOOL; i++)
        begin
            l1_mem[i] = pixel_t'(20'hd0000 | (i * 20'h01011));
        end

        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // Idle outputs before the start from ready
        e0 = errors;
        @(negedge clk);
        check_flag("busy after reset", busy, 1'b0);
        check_flag("cwr after reset", cwr, 1'b0);
        check_flag("crd after reset", crd, 1'b0);
        check_csel("csel after reset", csel, CSEL_NONE);
        idle = $urandom_range(9, 2);
        repeat (idle)
        begin
            @(negedge clk);
            check_flag("busy before ready", busy, 1'b0);
        end
        @(posedge clk);
        ready <= 1'b1;
        @(negedge clk);
        check_flag("busy in the cycle ready rises", busy, 1'b0);
        @(negedge clk);
        check_flag("busy one clock after ready", busy, 1'b1);
        @(posedge clk);
        ready <= 1'b0;
        report_test(1, "reset and start", errors - e0);

        while (busy)
        begin
            @(negedge clk);
        end
        repeat (3)
        begin
            @(negedge clk);
            check_flag("busy after the run", busy, 1'b0);
        end

        e0 = errors;
        for (int i = 0; i < NPIX; i++)
        begin
            if (rom_hits[i] != 1)
            begin
                fail_plain($sformatf("ROM address %0d was read %0d times", i, rom_hits[i]));
            end
        end
        report_test(2, "ROM load", errors - e0 + rom_errs);

        e0 = errors;
        if (l0_writes != NPIX)
        begin
            fail_plain($sformatf("%0d layer-0 writes seen, %0d expected", l0_writes, NPIX));
        end
        for (int i = 0; i < NPIX; i++)
        begin
            check_pixel($sformatf("layer0[%0d]", i), l0_mem[i], stim[NPIX+i]);
        end
        report_test(3, "layer-0 convolution", errors - e0 + l0_errs);

        // ReLU leaves no negative value in the frame
        e0 = errors;
        neg_count = 0;
        for (int i = 0; i < NPIX; i++)
        begin
            check_flag($sformatf("layer0[%0d] sign", i), l0_mem[i][PIXEL_W-1], 1'b0);
            if (stim[NPIX+i] == '0)
            begin
                neg_count++;
            end
        end
        if (neg_count == 0)
        begin
            fail_plain("stimulus has no clipped layer-0 position");
        end
        report_test(4, "ReLU", errors - e0);

        e0 = errors;
        if (l0_reads != NPIX)
        begin
            fail_plain($sformatf("%0d layer-0 reads seen, %0d expected", l0_reads, NPIX));
        end
        if (l1_writes != NPOOL)
        begin
            fail_plain($sformatf("%0d layer-1 writes seen, %0d expected", l1_writes, NPOOL));
        end
        if (writes_at_fall != NPOOL)
        begin
            fail_plain("busy fell before the last layer-1 write");
        end
        for (int i = 0; i < NPOOL; i++)
        begin
            check_pixel($sformatf("layer1[%0d]", i), l1_mem[i], stim[2*NPIX+i]);
        end
        report_test(5, "max pooling", errors - e0 + l1_errs);

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- testbench/conv_stimulus.txt
// Words 0..15 input pixels, words 16..31 expected layer-0, words 32..35 expected layer-1
// Raster order, 20-bit signed hex with 16 fraction bits
// Input frame, row 0
10000
00000
00000
20000
// Input frame, row 1
00000
10000
00000
00000
// Input frame, row 2
00000
00000
30000
00000
// Input frame, row 3
10000
00000
00000
10000
// Layer 0, row 0 (all sums negative)
00000
00000
00000
00000
// Layer 0, row 1
01439
00000
05636
02d3f
// Layer 0, row 2
04887
00000
00000
00b50
// Layer 0, row 3
00000
16add
139e3
1a55b
// Layer 1, pooled 2x2 maxima
01439
05636
16add
1a55b

//--- src.f
src/conv_pkg.sv
src/layer_ctrl.sv
src/image_buffer.sv
src/conv_mac.sv
src/max_pool.sv
src/conv_accel.sv
testbench/conv_accel_props.sv
testbench/tb_conv_accel.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_conv_accel
DUT_TOP   ?= conv_accel
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || (echo "Simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
